//--- common/cpu_pkg.sv
// --------------------------------------------------------------------------
// CPU shared definitions
// Bus widths, reset vector addresses, opcode encodings, sequencer states,
// ALU operations and the instruction classes used by the decoder
// --------------------------------------------------------------------------

package cpu_pkg;

  // Bus widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // Reset vector, low byte first as on the 6502
  localparam addr_t RESET_VECTOR_LO = 16'hFFFC;
  localparam addr_t RESET_VECTOR_HI = 16'hFFFD;

  // Kept opcodes, standard 6502 encodings
  typedef enum logic [7:0] {
    OP_LDA = 8'hAD,
    OP_STA = 8'h8D,
    OP_ADC = 8'h6D,
    OP_AND = 8'h2D,
    OP_ORA = 8'h0D,
    OP_EOR = 8'h4D,
    OP_INC = 8'hEE,
    OP_DEC = 8'hCE,
    OP_JMP = 8'h4C,
    OP_CLC = 8'h18,
    OP_NOP = 8'hEA
  } opcode_e;

  // Sequencer states, one bit per state
  typedef enum logic [9:0] {
    ST_RESET    = 10'b00_0000_0001,
    ST_VECTOR_1 = 10'b00_0000_0010,
    ST_VECTOR_2 = 10'b00_0000_0100,
    ST_FETCH    = 10'b00_0000_1000,
    ST_DECODE   = 10'b00_0001_0000,
    ST_ABS_1    = 10'b00_0010_0000,
    ST_ABS_2    = 10'b00_0100_0000,
    ST_ABS_3    = 10'b00_1000_0000,
    ST_ABS_4    = 10'b01_0000_0000,
    ST_HALT     = 10'b10_0000_0000
  } state_e;

  // ALU operations
  typedef enum logic [2:0] {
    ALU_PASS = 3'd0,
    ALU_ADD  = 3'd1,
    ALU_SUB  = 3'd2,
    ALU_AND  = 3'd3,
    ALU_OR   = 3'd4,
    ALU_XOR  = 3'd5
  } alu_op_e;

  // Path taken through the sequencer after DECODE
  typedef enum logic [2:0] {
    CLS_IMPLIED   = 3'd0,
    CLS_ABS_READ  = 3'd1,
    CLS_ABS_STORE = 3'd2,
    CLS_ABS_RMW   = 3'd3,
    CLS_ABS_JUMP  = 3'd4,
    CLS_ILLEGAL   = 3'd5
  } instr_class_e;

endpackage

//--- common/alu_if.sv
// --------------------------------------------------------------------------
// ALU request and result bundle between sequencer and ALU
// Operands are registered by the sequencer, the result is combinational
// --------------------------------------------------------------------------

`timescale 1ns/10ps

interface alu_if;

  // Request, registered in the sequencer
  cpu_pkg::alu_op_e op;
  cpu_pkg::data_t   a;
  cpu_pkg::data_t   b;
  logic             carry_in;

  // Result, valid the cycle after the operands load
  cpu_pkg::data_t   y;
  logic             carry_out;

  modport seq (
    output op, a, b, carry_in,
    input  y, carry_out
  );

  modport alu (
    input  op, a, b, carry_in,
    output y, carry_out
  );

endinterface

//--- core/cpu_decoder.sv
// --------------------------------------------------------------------------
// CPU instruction decoder
// Maps an opcode to its sequencer path, ALU operation and write-back
// --------------------------------------------------------------------------

`timescale 1ns/10ps

module cpu_decoder (
  input  cpu_pkg::opcode_e      ir,
  output cpu_pkg::instr_class_e instr_class,
  output cpu_pkg::alu_op_e      alu_op,
  output logic                  writes_acc,
  output logic                  writes_carry,
  output logic                  uses_carry,
  output logic                  operand_is_one
);

  always_comb begin
    // Defaults cover STA, JMP and NOP almost entirely
    instr_class    = cpu_pkg::CLS_ILLEGAL;
    alu_op         = cpu_pkg::ALU_PASS;
    writes_acc     = 1'b0;
    writes_carry   = 1'b0;
    uses_carry     = 1'b0;
    operand_is_one = 1'b0;

    case (ir)
      // Loads go through the ALU as a pass of the memory byte
      cpu_pkg::OP_LDA: begin
        instr_class = cpu_pkg::CLS_ABS_READ;
        writes_acc  = 1'b1;
      end
      cpu_pkg::OP_STA: instr_class = cpu_pkg::CLS_ABS_STORE;
      // Only ADC both reads and updates carry
      cpu_pkg::OP_ADC: begin
        instr_class  = cpu_pkg::CLS_ABS_READ;
        alu_op       = cpu_pkg::ALU_ADD;
        writes_acc   = 1'b1;
        writes_carry = 1'b1;
        uses_carry   = 1'b1;
      end
      cpu_pkg::OP_AND: begin
        instr_class = cpu_pkg::CLS_ABS_READ;
        alu_op      = cpu_pkg::ALU_AND;
        writes_acc  = 1'b1;
      end
      cpu_pkg::OP_ORA: begin
        instr_class = cpu_pkg::CLS_ABS_READ;
        alu_op      = cpu_pkg::ALU_OR;
        writes_acc  = 1'b1;
      end
      cpu_pkg::OP_EOR: begin
        instr_class = cpu_pkg::CLS_ABS_READ;
        alu_op      = cpu_pkg::ALU_XOR;
        writes_acc  = 1'b1;
      end
      // Memory byte plus or minus a constant one, carry untouched
      cpu_pkg::OP_INC: begin
        instr_class    = cpu_pkg::CLS_ABS_RMW;
        alu_op         = cpu_pkg::ALU_ADD;
        operand_is_one = 1'b1;
      end
      cpu_pkg::OP_DEC: begin
        instr_class    = cpu_pkg::CLS_ABS_RMW;
        alu_op         = cpu_pkg::ALU_SUB;
        operand_is_one = 1'b1;
      end
      cpu_pkg::OP_JMP: instr_class = cpu_pkg::CLS_ABS_JUMP;
      // CLC writes carry with no ALU use, which clears it
      cpu_pkg::OP_CLC: begin
        instr_class  = cpu_pkg::CLS_IMPLIED;
        writes_carry = 1'b1;
      end
      cpu_pkg::OP_NOP: instr_class = cpu_pkg::CLS_IMPLIED;
      default: begin
      end
    endcase
  end

endmodule

//--- design/cpu_alu.sv
// --------------------------------------------------------------------------
// CPU arithmetic and logic unit
// 8-bit add, subtract, bitwise logic and pass on registered operands
// --------------------------------------------------------------------------

`timescale 1ns/10ps

module cpu_alu (
  alu_if.alu alu
);

  // Nine bits to keep the carry out of the adder
  logic [cpu_pkg::DATA_W:0] sum;
  cpu_pkg::data_t           addend;

  // Subtract is add of the inverted operand
  always_comb begin
    if (alu.op == cpu_pkg::ALU_SUB) begin
      addend = ~alu.b;
    end else begin
      addend = alu.b;
    end
  end

  assign sum = {1'b0, alu.a} + {1'b0, addend} + {{cpu_pkg::DATA_W{1'b0}}, alu.carry_in};

  // --------------------------------------------------------------------------
  // Result select
  // --------------------------------------------------------------------------

  always_comb begin
    alu.y         = '0;
    alu.carry_out = 1'b0;
    case (alu.op)
      cpu_pkg::ALU_PASS: begin
        alu.y = alu.b;
      end
      cpu_pkg::ALU_ADD,
      cpu_pkg::ALU_SUB: begin
        alu.y         = sum[cpu_pkg::DATA_W-1:0];
        alu.carry_out = sum[cpu_pkg::DATA_W];
      end
      // Logic operations leave carry out low
      cpu_pkg::ALU_AND: begin
        alu.y = alu.a & alu.b;
      end
      cpu_pkg::ALU_OR: begin
        alu.y = alu.a | alu.b;
      end
      cpu_pkg::ALU_XOR: begin
        alu.y = alu.a ^ alu.b;
      end
      default: begin
        alu.y = alu.b;
      end
    endcase
  end

endmodule

//--- core/cpu_sequencer.sv
// --------------------------------------------------------------------------
// CPU instruction sequencer
// Reset vector fetch, instruction fetch and decode, absolute addressing
// sequences, accumulator and carry write-back, halt on illegal opcodes
// --------------------------------------------------------------------------

`timescale 1ns/10ps

module cpu_sequencer (
  input  logic           clk,
  input  logic           resetn,
  input  cpu_pkg::data_t rd_data,
  output cpu_pkg::addr_t address,
  output cpu_pkg::data_t wr_data,
  output logic           wr_enable,
  output logic           halted,
  alu_if.seq             alu
);

  // Architectural registers
  cpu_pkg::addr_t  pc;
  cpu_pkg::opcode_e ir;
  cpu_pkg::data_t  acc;
  logic            carry;

  // Absolute operand bytes
  cpu_pkg::data_t  operand_lo;
  cpu_pkg::data_t  operand_hi;

  cpu_pkg::state_e state;
  cpu_pkg::state_e next_state;

  // Decoder outputs for the opcode held in ir
  cpu_pkg::instr_class_e instr_class;
  cpu_pkg::alu_op_e      alu_op;
  logic                  writes_acc;
  logic                  writes_carry;
  logic                  uses_carry;
  logic                  operand_is_one;

  // --------------------------------------------------------------------------
  // Opcode decode
  // --------------------------------------------------------------------------

  // During FETCH ir still holds the previous instruction, so these outputs
  // describe the pending write-back there and the new opcode from DECODE on
  cpu_decoder i_cpu_decoder (
    .ir             (ir),
    .instr_class    (instr_class),
    .alu_op         (alu_op),
    .writes_acc     (writes_acc),
    .writes_carry   (writes_carry),
    .uses_carry     (uses_carry),
    .operand_is_one (operand_is_one)
  );

  // --------------------------------------------------------------------------
  // Next state
  // --------------------------------------------------------------------------

  always_comb begin
    next_state = state;
    case (state)
      cpu_pkg::ST_RESET:    next_state = cpu_pkg::ST_VECTOR_1;
      cpu_pkg::ST_VECTOR_1: next_state = cpu_pkg::ST_VECTOR_2;
      cpu_pkg::ST_VECTOR_2: next_state = cpu_pkg::ST_FETCH;
      cpu_pkg::ST_FETCH:    next_state = cpu_pkg::ST_DECODE;
      cpu_pkg::ST_DECODE: begin
        // Implied instructions finish here
        if (instr_class == cpu_pkg::CLS_IMPLIED) begin
          next_state = cpu_pkg::ST_FETCH;
        end else if (instr_class == cpu_pkg::CLS_ILLEGAL) begin
          next_state = cpu_pkg::ST_HALT;
        end else begin
          next_state = cpu_pkg::ST_ABS_1;
        end
      end
      cpu_pkg::ST_ABS_1: begin
        // JMP is a 3-cycle instruction
        if (instr_class == cpu_pkg::CLS_ABS_JUMP) begin
          next_state = cpu_pkg::ST_FETCH;
        end else begin
          next_state = cpu_pkg::ST_ABS_2;
        end
      end
      cpu_pkg::ST_ABS_2: begin
        // Only read-modify-write continues past ABS_2
        if (instr_class == cpu_pkg::CLS_ABS_RMW) begin
          next_state = cpu_pkg::ST_ABS_3;
        end else begin
          next_state = cpu_pkg::ST_FETCH;
        end
      end
      cpu_pkg::ST_ABS_3:    next_state = cpu_pkg::ST_ABS_4;
      cpu_pkg::ST_ABS_4:    next_state = cpu_pkg::ST_FETCH;
      cpu_pkg::ST_HALT:     next_state = cpu_pkg::ST_HALT;
      default:              next_state = cpu_pkg::ST_HALT;
    endcase
  end

  // --------------------------------------------------------------------------
  // Control registers, PC, address bus and flags
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state     <= cpu_pkg::ST_RESET;
      // Vector low byte is already on the bus when reset releases
      address   <= cpu_pkg::RESET_VECTOR_LO;
      wr_enable <= 1'b0;
      halted    <= 1'b0;
      // NOP in ir keeps the first FETCH from writing anything back
      ir        <= cpu_pkg::OP_NOP;
      carry     <= 1'b0;
      pc        <= '0;
    end else begin
      state <= next_state;
      case (state)
        cpu_pkg::ST_VECTOR_1: begin
          pc[7:0] <= rd_data;
          address <= cpu_pkg::RESET_VECTOR_HI;
        end
        cpu_pkg::ST_VECTOR_2: begin
          pc[15:8] <= rd_data;
          address  <= {rd_data, pc[7:0]};
        end
        cpu_pkg::ST_FETCH: begin
          ir      <= cpu_pkg::opcode_e'(rd_data);
          address <= pc + cpu_pkg::ADDR_W'(1);
          // ADC takes carry from the ALU, CLC marks carry without it and clears
          if (writes_carry) begin
            carry <= alu.carry_out & uses_carry;
          end
        end
        cpu_pkg::ST_DECODE: begin
          if (instr_class == cpu_pkg::CLS_IMPLIED) begin
            pc      <= pc + cpu_pkg::ADDR_W'(1);
            address <= pc + cpu_pkg::ADDR_W'(1);
          end else if (instr_class == cpu_pkg::CLS_ILLEGAL) begin
            halted <= 1'b1;
          end else begin
            address <= pc + cpu_pkg::ADDR_W'(2);
          end
        end
        cpu_pkg::ST_ABS_1: begin
          address <= {rd_data, operand_lo};
          if (instr_class == cpu_pkg::CLS_ABS_JUMP) begin
            pc <= {rd_data, operand_lo};
          end
          // STA drives its write strobe for exactly ABS_2
          if (instr_class == cpu_pkg::CLS_ABS_STORE) begin
            wr_enable <= 1'b1;
          end
        end
        cpu_pkg::ST_ABS_2: begin
          wr_enable <= 1'b0;
          // RMW keeps the operand address for the write in ABS_4
          if (instr_class != cpu_pkg::CLS_ABS_RMW) begin
            pc      <= pc + cpu_pkg::ADDR_W'(3);
            address <= pc + cpu_pkg::ADDR_W'(3);
          end
        end
        cpu_pkg::ST_ABS_3: begin
          address   <= {operand_hi, operand_lo};
          wr_enable <= 1'b1;
        end
        cpu_pkg::ST_ABS_4: begin
          wr_enable <= 1'b0;
          pc        <= pc + cpu_pkg::ADDR_W'(3);
          address   <= pc + cpu_pkg::ADDR_W'(3);
        end
        default: begin
        end
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Accumulator, operand latches, write data and ALU operands
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    case (state)
      cpu_pkg::ST_FETCH: begin
        // Result of the previous instruction lands while this one is fetched
        if (writes_acc) begin
          acc <= alu.y;
        end
      end
      cpu_pkg::ST_DECODE: begin
        operand_lo <= rd_data;
      end
      cpu_pkg::ST_ABS_1: begin
        operand_hi <= rd_data;
        wr_data    <= acc;
      end
      cpu_pkg::ST_ABS_2: begin
        // INC and DEC work on the memory byte, the others on A and memory
        alu.op <= alu_op;
        alu.a  <= operand_is_one ? rd_data : acc;
        alu.b  <= operand_is_one ? cpu_pkg::DATA_W'(1) : rd_data;
        // Subtraction needs carry in set for a true two's complement
        alu.carry_in <= uses_carry ? carry : (alu_op == cpu_pkg::ALU_SUB);
      end
      cpu_pkg::ST_ABS_3: begin
        wr_data <= alu.y;
      end
      default: begin
      end
    endcase
  end

endmodule

//--- design/cpu_top.sv
// --------------------------------------------------------------------------
// CPU top level
// Reduced 6502-style core: instruction sequencer plus internal ALU,
// with an asynchronous-read memory bus and a halt indication
// --------------------------------------------------------------------------

`timescale 1ns/10ps

module cpu_top (
  input  logic           clk,
  input  logic           resetn,
  input  cpu_pkg::data_t rd_data,
  output cpu_pkg::addr_t address,
  output cpu_pkg::data_t wr_data,
  output logic           wr_enable,
  output logic           halted
);

  // --------------------------------------------------------------------------
  // Sequencer to ALU link
  // --------------------------------------------------------------------------

  alu_if i_alu_if ();

  // --------------------------------------------------------------------------
  // Instruction sequencer, owns the memory bus
  // --------------------------------------------------------------------------

  cpu_sequencer i_cpu_sequencer (
    .clk       (clk),
    .resetn    (resetn),
    .rd_data   (rd_data),
    .address   (address),
    .wr_data   (wr_data),
    .wr_enable (wr_enable),
    .halted    (halted),
    .alu       (i_alu_if.seq)
  );

  // --------------------------------------------------------------------------
  // Arithmetic and logic unit
  // --------------------------------------------------------------------------

  cpu_alu i_cpu_alu (
    .alu (i_alu_if.alu)
  );

endmodule

//--- sim/cpu_sva.sv
// --------------------------------------------------------------------------
// CPU bus and halt assertions
// Single-cycle write strobe, sticky halt, clean outputs after reset
// --------------------------------------------------------------------------

`timescale 1ns/10ps

module cpu_sva (
  input logic clk,
  input logic resetn,
  input logic wr_enable,
  input logic halted
);

  // Write strobe is a one-cycle pulse
  assert property (@(posedge clk) disable iff (!resetn) wr_enable |=> !wr_enable)
    else $error("wr_enable high in two consecutive cycles");

  // Only reset leaves the halt state
  assert property (@(posedge clk) disable iff (!resetn) halted |=> halted)
    else $error("halted fell without a reset");

  // Synchronous reset clears strobe and halt flag
  assert property (@(posedge clk) !resetn |=> !wr_enable && !halted)
    else $error("wr_enable or halted high after a reset cycle");

endmodule

bind cpu_top cpu_sva i_cpu_sva (
  .clk       (clk),
  .resetn    (resetn),
  .wr_enable (wr_enable),
  .halted    (halted)
);

//--- sim/tb_cpu.sv
// --------------------------------------------------------------------------
// Directed testbench for the CPU top level
// Asynchronous memory model, reset sequencing and six program-level tests
// checked against a log of the memory writes
// --------------------------------------------------------------------------

`timescale 1ns/10ps

module tb_cpu;

  localparam int MEM_DEPTH = 65536;
  localparam int SEED      = 42;

  logic           clk;
  logic           resetn;
  cpu_pkg::data_t rd_data;
  cpu_pkg::addr_t address;
  cpu_pkg::data_t wr_data;
  logic           wr_enable;
  logic           halted;

  // Memory image, observed writes and the writes a test expects
  cpu_pkg::data_t mem [0:MEM_DEPTH-1];
  cpu_pkg::addr_t wr_addr_q[$];
  cpu_pkg::data_t wr_data_q[$];
  cpu_pkg::addr_t exp_addr_q[$];
  cpu_pkg::data_t exp_data_q[$];
  cpu_pkg::addr_t start_addr;
  cpu_pkg::addr_t prog_ptr;
  int             value_errors;
  int             other_errors;

  cpu_top i_cpu_top (
    .clk       (clk),
    .resetn    (resetn),
    .rd_data   (rd_data),
    .address   (address),
    .wr_data   (wr_data),
    .wr_enable (wr_enable),
    .halted    (halted)
  );

  always #20 clk = ~clk;

  // Read is asynchronous
  assign rd_data = mem[address];

  // Write lands on the clock edge that ends the strobe cycle
  always @(posedge clk) begin
    if (wr_enable) begin
      mem[address] <= wr_data;
      wr_addr_q.push_back(address);
      wr_data_q.push_back(wr_data);
    end
  end

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------

  task automatic check_data(string name, cpu_pkg::data_t got, cpu_pkg::data_t exp);
    if (got !== exp) begin
      $display("error %s: got %h, expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_addr(string name, cpu_pkg::addr_t got, cpu_pkg::addr_t exp);
    if (got !== exp) begin
      $display("error %s: got %h, expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  // --------------------------------------------------------------------------
  // Program building
  // --------------------------------------------------------------------------

  // Cleared bytes read as 00, which is no kept opcode
  // So every program halts where its code ends
  task automatic new_program(cpu_pkg::addr_t base);
    for (int i = 0; i < MEM_DEPTH; i++) begin
      mem[i] <= '0;
    end
    mem[cpu_pkg::RESET_VECTOR_LO] <= base[7:0];
    mem[cpu_pkg::RESET_VECTOR_HI] <= base[15:8];
    start_addr = base;
    prog_ptr   = base;
    exp_addr_q.delete();
    exp_data_q.delete();
  endtask

  task automatic random_byte(cpu_pkg::addr_t a, output cpu_pkg::data_t d);
    d = cpu_pkg::data_t'($urandom);
    mem[a] <= d;
  endtask

  task automatic emit_byte(cpu_pkg::data_t b);
    mem[prog_ptr] <= b;
    prog_ptr = prog_ptr + 16'd1;
  endtask

  // Opcode, then operand address low byte first
  task automatic emit_abs(cpu_pkg::opcode_e op, cpu_pkg::addr_t target);
    emit_byte(op);
    emit_byte(target[7:0]);
    emit_byte(target[15:8]);
  endtask

  task automatic expect_write(cpu_pkg::addr_t a, cpu_pkg::data_t d);
    exp_addr_q.push_back(a);
    exp_data_q.push_back(d);
  endtask

  // Reset, run to the halt and compare the write log
  task automatic run_program();
    cpu_pkg::addr_t held;
    int             cycles;
    @(posedge clk);
    resetn <= 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_addr("address", address, cpu_pkg::RESET_VECTOR_LO);
    wr_addr_q.delete();
    wr_data_q.delete();
    @(posedge clk);
    resetn <= 1'b1;
    // Vector is on the bus at the first FETCH
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_addr("address", address, start_addr);
    cycles = 0;
    while (!halted && cycles < 200) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      $display("halted did not rise within 200 cycles of the program start");
      other_errors++;
    end
    // A halted core keeps its address and writes nothing more
    held = address;
    repeat (8) begin
      @(negedge clk);
      check_addr("address", address, held);
    end
    if (wr_addr_q.size() != exp_addr_q.size()) begin
      $display("saw %0d memory writes where %0d were expected",
               wr_addr_q.size(), exp_addr_q.size());
      other_errors++;
    end
    foreach (exp_addr_q[i]) begin
      if (i < wr_addr_q.size()) begin
        check_addr("address", wr_addr_q[i], exp_addr_q[i]);
        check_data("wr_data", wr_data_q[i], exp_data_q[i]);
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------

  // LDA then STA, placed at the address held in the reset vector
  task automatic reset_vector_program();
    cpu_pkg::data_t d;
    new_program(16'hC3A0);
    random_byte(16'h4010, d);
    emit_abs(cpu_pkg::OP_LDA, 16'h4010);
    emit_abs(cpu_pkg::OP_STA, 16'h5020);
    expect_write(16'h5020, d);
    run_program();
  endtask

  task automatic logic_op_chain();
    cpu_pkg::data_t d [4];
    cpu_pkg::data_t r;
    new_program(16'h0200);
    foreach (d[i]) begin
      random_byte(cpu_pkg::addr_t'(16'h3000 + i), d[i]);
    end
    emit_abs(cpu_pkg::OP_LDA, 16'h3000);
    emit_abs(cpu_pkg::OP_AND, 16'h3001);
    emit_abs(cpu_pkg::OP_STA, 16'h3010);
    emit_abs(cpu_pkg::OP_ORA, 16'h3002);
    emit_abs(cpu_pkg::OP_STA, 16'h3011);
    emit_abs(cpu_pkg::OP_EOR, 16'h3003);
    emit_abs(cpu_pkg::OP_STA, 16'h3012);
    // Running bitwise result of the accumulator
    r = d[0] & d[1];
    expect_write(16'h3010, r);
    r = r | d[2];
    expect_write(16'h3011, r);
    r = r ^ d[3];
    expect_write(16'h3012, r);
    run_program();
  endtask

  // Second ADC adds zero, so its result is the low byte plus the carry
  task automatic carry_chain();
    cpu_pkg::data_t a;
    cpu_pkg::data_t b;
    logic [8:0]     sum;
    new_program(16'h0200);
    random_byte(16'h3000, a);
    random_byte(16'h3001, b);
    // Top bits set so the first sum always carries out
    a[7] = 1'b1;
    b[7] = 1'b1;
    mem[16'h3000] <= a;
    mem[16'h3001] <= b;
    emit_byte(cpu_pkg::OP_CLC);
    emit_abs(cpu_pkg::OP_LDA, 16'h3000);
    emit_abs(cpu_pkg::OP_ADC, 16'h3001);
    emit_abs(cpu_pkg::OP_STA, 16'h3010);
    emit_abs(cpu_pkg::OP_ADC, 16'h3002);
    emit_abs(cpu_pkg::OP_STA, 16'h3011);
    sum = {1'b0, a} + {1'b0, b};
    expect_write(16'h3010, sum[7:0]);
    expect_write(16'h3011, sum[7:0] + cpu_pkg::data_t'(sum[8]));
    run_program();
  endtask

  task automatic read_modify_write();
    cpu_pkg::data_t a;
    cpu_pkg::data_t b;
    new_program(16'h0200);
    mem[16'h3100] <= 8'hFF;
    mem[16'h3101] <= 8'h00;
    random_byte(16'h3102, a);
    random_byte(16'h3103, b);
    // FF plus FF sets carry, which the CLC below has to clear
    emit_abs(cpu_pkg::OP_LDA, 16'h3100);
    emit_abs(cpu_pkg::OP_ADC, 16'h3100);
    emit_byte(cpu_pkg::OP_CLC);
    emit_abs(cpu_pkg::OP_LDA, 16'h3102);
    emit_abs(cpu_pkg::OP_DEC, 16'h3101);
    // INC of FF carries out of the adder and goes last
    emit_abs(cpu_pkg::OP_INC, 16'h3100);
    emit_abs(cpu_pkg::OP_ADC, 16'h3103);
    emit_abs(cpu_pkg::OP_STA, 16'h3110);
    expect_write(16'h3101, 8'hFF);
    expect_write(16'h3100, 8'h00);
    expect_write(16'h3110, a + b);
    run_program();
  endtask

  task automatic jump_over_store();
    cpu_pkg::data_t d;
    new_program(16'h0200);
    random_byte(16'h3000, d);
    emit_abs(cpu_pkg::OP_LDA, 16'h3000);
    emit_abs(cpu_pkg::OP_JMP, 16'h0280);
    emit_abs(cpu_pkg::OP_STA, 16'h3010);
    prog_ptr = 16'h0280;
    emit_byte(cpu_pkg::OP_NOP);
    emit_byte(cpu_pkg::OP_NOP);
    emit_abs(cpu_pkg::OP_STA, 16'h3020);
    expect_write(16'h3020, d);
    run_program();
  endtask

  task automatic illegal_opcode_halt();
    cpu_pkg::data_t d;
    new_program(16'h0200);
    random_byte(16'h3000, d);
    emit_abs(cpu_pkg::OP_LDA, 16'h3000);
    emit_abs(cpu_pkg::OP_STA, 16'h3010);
    // 02 is not a kept opcode
    // The store behind it must never run
    emit_byte(8'h02);
    emit_abs(cpu_pkg::OP_STA, 16'h3020);
    expect_write(16'h3010, d);
    run_program();
  endtask

  initial begin
    clk          = 1'b0;
    resetn       = 1'b0;
    value_errors = 0;
    other_errors = 0;
    void'($urandom(SEED));
    reset_vector_program();
    logic_op_chain();
    carry_chain();
    read_modify_write();
    jump_over_store();
    illegal_opcode_halt();
    $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- flist.f
common/cpu_pkg.sv
common/alu_if.sv
core/cpu_decoder.sv
design/cpu_alu.sv
core/cpu_sequencer.sv
design/cpu_top.sv
sim/cpu_sva.sv
sim/tb_cpu.sv
